//--- uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

//////////////////////////////////////////////////////////////
// channel layout
//////////////////////////////////////////////////////////////

`define UART_CH_NUM 4     // transmit channels
`define UART_CH_BITS 2    // width of a channel number

//////////////////////////////////////////////////////////////
// frame and timing
//////////////////////////////////////////////////////////////

`define UART_DATA_BW 8    // data bits per frame, sent lsb first

// clk cycles per serial bit
// small on purpose so a frame fits in a short simulation
`define UART_BAUD_DIV 8
`define UART_BAUD_BITS 3  // divider counter width, holds 0..UART_BAUD_DIV-1

`define UART_FCNT_BW 16   // finished frame counter, wraps

`endif

//--- uart_frame_pkg.sv
`include "uart_defs.svh"

// types describing one serial frame on a tx line
package uart_frame_pkg;

	// transmitter states, one frame walks them in order
	typedef enum logic [2:0] {
		TX_IDLE,   // line held high
		TX_WAIT,   // request held, waiting for a tick
		TX_START,  // start bit on the line
		TX_DATA,   // data bits, lsb first
		TX_STOP    // stop bit on the line
	} tx_state_t;

	// index of the data bit currently on the line
	typedef logic [$clog2(`UART_DATA_BW)-1:0] bit_idx_t;

endpackage

//--- uart_chan_pkg.sv
`include "uart_defs.svh"

// types for channel addressing and status reporting
package uart_chan_pkg;

	// channel number carried with every write
	typedef logic [`UART_CH_BITS-1:0] ch_id_t;

	// one busy flag per channel
	typedef logic [`UART_CH_NUM-1:0] busy_vec_t;

	// count of finished frames over all channels
	typedef logic [`UART_FCNT_BW-1:0] frame_cnt_t;

endpackage

//--- tx_chan_if.sv
`include "uart_defs.svh"

// link between dispatcher, one transmit channel and the status collector
interface tx_chan_if;

	logic start;                      // one cycle request pulse
	logic [`UART_DATA_BW-1:0] data;   // byte, valid with start
	logic baud_tick;                  // shared bit timing pulse
	logic busy;                       // channel owns a frame
	logic done;                       // one cycle at end of stop bit

	// dispatcher side
	modport disp (
		output start,
		output data,
		output baud_tick,
		input busy
	);

	// transmitter side
	modport chan (
		input start,
		input data,
		input baud_tick,
		output busy,
		output done
	);

	// status side, watches only
	modport stat (
		input busy,
		input done
	);

endinterface

//--- tx_dispatch.sv
`include "uart_defs.svh"

module tx_dispatch (
	input logic clk,
	input logic rst,
	input logic wr,                            // write strobe
	input uart_chan_pkg::ch_id_t ch,           // target channel
	input logic [`UART_DATA_BW-1:0] data,      // byte to send
	tx_chan_if.disp chan [`UART_CH_NUM]
);

	import uart_chan_pkg::*;

	logic [`UART_BAUD_BITS-1:0] div_cnt;
	logic baud_tick;
	busy_vec_t busy_in;   // busy straight from the channels
	busy_vec_t pend;      // accepted but busy not up yet
	busy_vec_t accept;
	busy_vec_t start_q;
	logic [`UART_DATA_BW-1:0] data_q;

	//////////////////////////////////////////////////////////////
	// baud divider
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			div_cnt <= '0;
		end else if (div_cnt == `UART_BAUD_BITS'(`UART_BAUD_DIV - 1)) begin
			div_cnt <= '0;  // wrap
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign baud_tick = (div_cnt == `UART_BAUD_BITS'(`UART_BAUD_DIV - 1));

	//////////////////////////////////////////////////////////////
	// per channel accept and routing
	//////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `UART_CH_NUM; i++) begin : g_route
		assign busy_in[i] = chan[i].busy;
		// addressed, not busy, no start in flight
		assign accept[i] = wr && (ch == ch_id_t'(i)) && !(busy_in[i] || pend[i]);
		assign chan[i].start = start_q[i];
		assign chan[i].data = data_q;          // shared byte reg, only one start at a time
		assign chan[i].baud_tick = baud_tick;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			start_q <= '0;
			pend <= '0;
		end else begin
			start_q <= accept;                   // one cycle pulse
			pend <= (pend & ~busy_in) | accept;  // holds until busy is seen
		end
	end

	// payload register
	always_ff @(posedge clk) begin
		if (|accept) begin
			data_q <= data;
		end
	end

endmodule

//--- uart_tx_chan.sv
`include "uart_defs.svh"

module uart_tx_chan (
	input logic clk,
	input logic rst,
	tx_chan_if.chan link,
	output logic tx        // serial line, idles high
);

	import uart_frame_pkg::*;

	tx_state_t state;
	bit_idx_t bit_idx;
	logic [`UART_DATA_BW-1:0] shreg;   // byte being shifted out
	logic done_q;

	//////////////////////////////////////////////////////////////
	// frame fsm, moves on baud ticks only
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= TX_IDLE;
			bit_idx <= '0;
			tx <= 1'b1;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				TX_IDLE: begin
					tx <= 1'b1;
					if (link.start) begin
						if (link.baud_tick) begin
							state <= TX_START;  // tick in the start cycle
							tx <= 1'b0;
						end else begin
							state <= TX_WAIT;
						end
					end
				end
				TX_WAIT: begin
					if (link.baud_tick) begin
						state <= TX_START;
						tx <= 1'b0;  // start bit
					end
				end
				TX_START: begin
					if (link.baud_tick) begin
						state <= TX_DATA;
						bit_idx <= '0;
						tx <= shreg[0];  // bit 0
					end
				end
				TX_DATA: begin
					if (link.baud_tick) begin
						if (bit_idx == bit_idx_t'(`UART_DATA_BW - 1)) begin
							state <= TX_STOP;
							tx <= 1'b1;  // stop bit
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx <= shreg[0];
						end
					end
				end
				TX_STOP: begin
					if (link.baud_tick) begin
						state <= TX_IDLE;
						done_q <= 1'b1;  // lines up with busy falling
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// shifter, sampled at start and consumed lsb first
	always_ff @(posedge clk) begin
		if (state == TX_IDLE && link.start) begin
			shreg <= link.data;
		end else if ((state == TX_START || state == TX_DATA) && link.baud_tick) begin
			shreg <= shreg >> 1;
		end
	end

	assign link.busy = (state != TX_IDLE);  // TX_WAIT through TX_STOP
	assign link.done = done_q;

endmodule

//--- tx_status_collect.sv
`include "uart_defs.svh"

module tx_status_collect (
	input logic clk,
	input logic rst,
	tx_chan_if.stat chan [`UART_CH_NUM],
	output uart_chan_pkg::busy_vec_t busy,          // registered, glitch free
	output logic done,                              // any frame finished
	output uart_chan_pkg::frame_cnt_t frames_sent   // wraps at full width
);

	import uart_chan_pkg::*;

	busy_vec_t busy_in;
	busy_vec_t done_in;
	logic [`UART_CH_BITS:0] n_done;  // holds 0..UART_CH_NUM

	for (genvar i = 0; i < `UART_CH_NUM; i++) begin : g_tap
		assign busy_in[i] = chan[i].busy;
		assign done_in[i] = chan[i].done;
	end

	// how many channels finished this cycle
	always_comb begin
		n_done = '0;
		for (int i = 0; i < `UART_CH_NUM; i++) begin
			n_done = n_done + done_in[i];
		end
	end

	//////////////////////////////////////////////////////////////
	// outside status registers
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= '0;
			done <= 1'b0;
			frames_sent <= '0;
		end else begin
			busy <= busy_in;      // one cycle behind the channels
			done <= |done_in;     // single pulse even if several end together
			frames_sent <= frames_sent + frame_cnt_t'(n_done);
		end
	end

endmodule

//--- multi_uart_tx.sv
`include "uart_defs.svh"

module multi_uart_tx (
	input logic clk,
	input logic rst,
	input logic wr,                                  // write strobe
	input uart_chan_pkg::ch_id_t ch,                 // channel select
	input logic [`UART_DATA_BW-1:0] data,            // byte to send
	output logic [`UART_CH_NUM-1:0] tx,              // serial lines
	output uart_chan_pkg::busy_vec_t busy,           // per channel busy
	output logic done,                               // frame finished pulse
	output uart_chan_pkg::frame_cnt_t frames_sent    // finished frame count
);

	tx_chan_if chan_if [`UART_CH_NUM] ();  // one link per channel

	// write routing and baud tick
	tx_dispatch i_tx_dispatch (
		.clk(clk),
		.rst(rst),
		.wr(wr),
		.ch(ch),
		.data(data),
		.chan(chan_if)
	);

	//////////////////////////////////////////////////////////////
	// transmit channels
	//////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `UART_CH_NUM; g++) begin : i_chan
		uart_tx_chan i_uart_tx_chan (
			.clk(clk),
			.rst(rst),
			.link(chan_if[g]),
			.tx(tx[g])
		);
	end

	// busy register, done pulse and frame count
	tx_status_collect i_tx_status_collect (
		.clk(clk),
		.rst(rst),
		.chan(chan_if),
		.busy(busy),
		.done(done),
		.frames_sent(frames_sent)
	);

endmodule

//--- multi_uart_tx_props.sv
module multi_uart_tx_props (
	input logic clk,
	input logic rst,
	input uart_chan_pkg::busy_vec_t busy,        // outside busy register
	input logic done,
	input uart_chan_pkg::frame_cnt_t frames_sent
);

	int fails = 0;  // failed property count

	//////////////////////////////////////////////////////////////
	// status output rules
	//////////////////////////////////////////////////////////////

	// back to back done only when another busy bit just fell
	a_done_single: assert property (@(posedge clk) disable iff (rst)
		done && $past(done) |-> |($past(busy) & ~busy))
		else begin
			$error("done high two cycles without a busy bit falling");
			fails++;
		end

	// counter moves together with done
	a_count_done: assert property (@(posedge clk) disable iff (rst)
		frames_sent != $past(frames_sent) |-> done)
		else begin
			$error("frames_sent changed without done");
			fails++;
		end

	a_reset_busy: assert property (@(posedge clk) $fell(rst) |-> busy == '0)
		else begin
			$error("busy not clear right after reset");
			fails++;
		end

endmodule

bind tx_status_collect multi_uart_tx_props i_multi_uart_tx_props (
	.clk(clk),
	.rst(rst),
	.busy(busy),
	.done(done),
	.frames_sent(frames_sent)
);

//--- tb_multi_uart_tx.sv
`include "uart_defs.svh"

module tb_multi_uart_tx;

	import uart_chan_pkg::*;

	localparam int DIV = `UART_BAUD_DIV;
	localparam int STIM_CYCLES = 400;                                 // random write phase
	localparam int TIMEOUT_CYCLES = (STIM_CYCLES + 12 * DIV * 4) * 2; // stimulus plus drain, doubled

	logic clk = 1'b0;
	logic rst;
	logic wr;
	ch_id_t ch;
	logic [`UART_DATA_BW-1:0] data;
	logic [`UART_CH_NUM-1:0] tx;
	busy_vec_t busy;
	logic done;
	frame_cnt_t frames_sent;

	// model state, at most one frame in flight per channel
	bit exp_valid [`UART_CH_NUM];               // accepted byte not yet decoded
	logic [`UART_DATA_BW-1:0] exp_byte [`UART_CH_NUM];
	bit dec_on [`UART_CH_NUM];                  // decoder inside a frame
	int dec_cnt [`UART_CH_NUM];                 // cycles since the falling edge
	logic [`UART_DATA_BW-1:0] dec_byte [`UART_CH_NUM];
	int last_stop [`UART_CH_NUM];               // when the last stop bit was seen
	int frames_dec [`UART_CH_NUM];
	int accepted [`UART_CH_NUM];
	int now;
	int cycles = 0;
	int checks;
	int errors;
	int prop_fails;                             // failed status properties
	int total;
	logic [31:0] rnd;

	multi_uart_tx i_multi_uart_tx (
		.clk(clk), .rst(rst), .wr(wr), .ch(ch), .data(data),
		.tx(tx), .busy(busy), .done(done), .frames_sent(frames_sent)
	);

	always #2 clk = ~clk;

	task automatic report_mismatch(string name, int exp_v, int act_v);
		errors++;
		$display("FAILED %s expected %0h actual %0h", name, exp_v, act_v);
	endtask

	function automatic bit model_busy(int k);
		return exp_valid[k] || dec_on[k];  // acceptance until the frame has left the line
	endfunction

	function automatic bit any_busy();
		bit b;
		b = 1'b0;
		for (int k = 0; k < `UART_CH_NUM; k++)
			b |= model_busy(k);
		return b;
	endfunction

	//////////////////////////////////////////////////////////////
	// line decoders, one sample per negedge
	//////////////////////////////////////////////////////////////

	task automatic watch_lines();
		int s;
		bit seen;
		now++;
		seen = 1'b0;
		for (int k = 0; k < `UART_CH_NUM; k++) begin
			if (dec_on[k]) begin
				dec_cnt[k]++;
				s = (dec_cnt[k] - DIV / 2) / DIV;  // bit number, 0 is the start bit
				if ((dec_cnt[k] - DIV / 2) % DIV == 0 && s <= 9) begin  // mid bit
					checks++;
					if (busy[k] !== 1'b1)
						report_mismatch("busy_flag", 1, busy[k]);
					if (s == 0 && tx[k] !== 1'b0)
						report_mismatch("frame_format", 0, tx[k]);
					else if (s >= 1 && s <= 8)
						dec_byte[k][s - 1] = tx[k];  // lsb first
					else if (s == 9) begin
						if (tx[k] !== 1'b1)
							report_mismatch("frame_format", 1, tx[k]);
						if (!exp_valid[k]) begin
							errors++;
							$display("frame on line %0d with no accepted write", k);
						end else if (dec_byte[k] !== exp_byte[k])
							report_mismatch("frame_data", exp_byte[k], dec_byte[k]);
						exp_valid[k] = 1'b0;
						frames_dec[k]++;
						last_stop[k] = now;
					end
				end
				if (dec_cnt[k] == 10 * DIV)
					dec_on[k] = 1'b0;  // stop bit over, line free
			end else if (tx[k] === 1'b0) begin
				dec_on[k] = 1'b1;  // falling edge, start bit
				dec_cnt[k] = 0;
			end
			if (now - last_stop[k] <= DIV)
				seen = 1'b1;
		end
		if (done === 1'b1 && !seen) begin
			errors++;
			$display("done pulse with no frame ended in the last %0d cycles", DIV);
		end
	endtask

	task automatic drive_write();
		rnd = $urandom;
		wr = rnd[0];
		ch = ch_id_t'(rnd[8 +: `UART_CH_BITS]);
		data = rnd[23:16];
		if (wr && !model_busy(ch)) begin  // model takes it, else dropped
			exp_valid[ch] = 1'b1;
			exp_byte[ch] = data;
			accepted[ch]++;
		end
	endtask

	//////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(56701));
		rst = 1'b1;
		wr = 1'b0;
		ch = '0;
		data = '0;
		now = 0;
		checks = 0;
		errors = 0;
		for (int k = 0; k < `UART_CH_NUM; k++) begin
			exp_valid[k] = 1'b0;
			dec_on[k] = 1'b0;
			dec_cnt[k] = 0;
			last_stop[k] = -1000;
			frames_dec[k] = 0;
			accepted[k] = 0;
		end
		repeat (5) @(negedge clk);
		rst = 1'b0;
		checks++;
		if (tx !== '1)
			report_mismatch("reset_idle", {`UART_CH_NUM{1'b1}}, tx);
		if (busy !== '0)
			report_mismatch("reset_idle", 0, busy);
		if (done !== 1'b0)
			report_mismatch("reset_idle", 0, done);
		if (frames_sent !== '0)
			report_mismatch("reset_idle", 0, frames_sent);
		repeat (STIM_CYCLES) begin
			@(negedge clk);
			watch_lines();
			drive_write();
		end
		@(negedge clk);
		wr = 1'b0;
		watch_lines();
		while (any_busy()) begin  // drain, timeout guards this
			@(negedge clk);
			watch_lines();
		end
		repeat (3) begin  // let done and the counter settle
			@(negedge clk);
			watch_lines();
		end
		total = 0;
		for (int k = 0; k < `UART_CH_NUM; k++) begin
			checks++;
			if (frames_dec[k] != accepted[k])
				report_mismatch("drop_busy", accepted[k], frames_dec[k]);
			total += frames_dec[k];
		end
		checks++;
		if (frames_sent !== frame_cnt_t'(total))
			report_mismatch("status_count", total, frames_sent);
		prop_fails = i_multi_uart_tx.i_tx_status_collect.i_multi_uart_tx_props.fails;
		errors += prop_fails;
		$display("checks %0d, errors %0d, property failures %0d, frames %0d",
			checks, errors, prop_fails, total);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, run not finished after %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

endmodule

//--- project.f
+incdir+.
uart_frame_pkg.sv
uart_chan_pkg.sv
tx_chan_if.sv
tx_dispatch.sv
uart_tx_chan.sv
tx_status_collect.sv
multi_uart_tx.sv
multi_uart_tx_props.sv
tb_multi_uart_tx.sv

//--- Bender.yml
package:
  name: multi_uart_tx

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uart_frame_pkg.sv
      - uart_chan_pkg.sv
      - tx_chan_if.sv
      - tx_dispatch.sv
      - uart_tx_chan.sv
      - tx_status_collect.sv
      - multi_uart_tx.sv
  - target: test
    include_dirs:
      - .
    files:
      - multi_uart_tx_props.sv
      - tb_multi_uart_tx.sv
